// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_fpga_board_top
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
+incdir+verilog
verilog/dbg_pkg.sv
verilog/fpga_reset.sv
verilog/activity_led.sv
verilog/uart_serial.sv
verilog/uart_bridge.sv
verilog/jtag_dtm.sv
verilog/bus_arbiter.sv
verilog/bus_ram.sv
verilog/fpga_board_top.sv
test/tb_fpga_board_top.sv

// ==== test/board_cases.txt ====
# name port op addr data expect, all hex; port is uart, jtag or both
# data * is a random word, expect m uses the memory model, - means none
uw_a  uart wr 10 1234 -
ur_a  uart rd 10 -    1234
jw_b  jtag wr 20 beef -
ur_b  uart rd 20 -    beef
uw_c  uart wr 30 *    -
jr_c  jtag rd 30 -    m
jw_d  jtag wr 31 *    -
jr_d  jtag rd 31 -    m
bw_e  both wr 40 *    -
br_e  both rd 40 -    m
bw_f  both wr 50 a55a -
ur_f  uart rd 51 -    5aa5
jr_f  jtag rd 50 -    a55a

// ==== test/tb_fpga_board_top.sv ====
// Run from the project root; cases come from test/board_cases.txt.
// The memory model only knows addresses that the cases write.
`include "dbg_config.svh"

module tb_fpga_board_top;

	localparam int bit_clks = `DBG_CLKS_PER_BIT;

	logic clk;
	logic button;
	logic tck;
	logic tms;
	logic tdi;
	logic tdo;
	logic led;
	logic mirror_tck;
	logic mirror_tms;
	logic mirror_tdi;
	logic mirror_tdo;
	logic uart_rx;
	logic uart_tx;

	dbg_pkg::data_t model [256];
	integer seed;
	int errors;
	int checks;
	int cycles;
	int limit;
	logic running;

	// Parsed case columns.
	string names[$];
	string ports[$];
	string ops[$];
	dbg_pkg::addr_t addrs[$];
	string datas[$];
	string expects[$];

	fpga_board_top fpga_board_top_inst (
		.clk_osc    (clk),
		.button     (button),
		.tck        (tck),
		.tms        (tms),
		.tdi        (tdi),
		.tdo        (tdo),
		.led        (led),
		.mirror_tck (mirror_tck),
		.mirror_tms (mirror_tms),
		.mirror_tdi (mirror_tdi),
		.mirror_tdo (mirror_tdo),
		.uart_rx    (uart_rx),
		.uart_tx    (uart_tx)
	);

	always #20 clk = ~clk;

	// Watchdog.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("Timeout: run passed its limit of %0d cycles", limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Mirrors follow the pins every cycle.
	always @(negedge clk) begin
		if (running)
			check("mirror", {12'd0, tck, tms, tdi, tdo},
				{12'd0, mirror_tck, mirror_tms, mirror_tdi, mirror_tdo});
	end

	task automatic check(input string name, input dbg_pkg::data_t exp,
		input dbg_pkg::data_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Sends one 8N1 frame LSB first.
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			uart_rx <= frame[i];
			repeat (bit_clks - 1) @(posedge clk);
		end
	endtask

	task automatic receive_byte(input string name, output logic [7:0] b);
		logic [9:0] frame;
		int wait_n;
		wait_n = 0;
		frame = '0;
		@(negedge clk);
		while (uart_tx !== 1'b0 && wait_n < 400) begin
			@(negedge clk);
			wait_n++;
		end
		if (uart_tx !== 1'b0) begin
			errors++;
			$display("%s: no reply byte came back on uart_tx", name);
		end else begin
			// Move to the start bit centre.
			repeat (bit_clks / 2) @(negedge clk);
			for (int i = 1; i < 10; i++) begin
				repeat (bit_clks) @(negedge clk);
				frame[i] = uart_tx;
			end
			if (frame[9] !== 1'b1) begin
				errors++;
				$display("%s: reply byte has no stop bit", name);
			end
		end
		b = frame[8:1];
	endtask

	// Sends W addr hi lo and waits for the bridge write response.
	task automatic bridge_write(input string name, input dbg_pkg::addr_t a,
		input dbg_pkg::data_t d);
		int wait_n;
		send_byte(dbg_pkg::op_write);
		send_byte(a);
		send_byte(d[15:8]);
		send_byte(d[7:0]);
		wait_n = 0;
		@(negedge clk);
		while (!(fpga_board_top_inst.m1_bvalid && fpga_board_top_inst.m1_bready)
			&& wait_n < 200) begin
			@(negedge clk);
			wait_n++;
		end
		if (!(fpga_board_top_inst.m1_bvalid && fpga_board_top_inst.m1_bready)) begin
			errors++;
			$display("%s: UART write got no bus response", name);
		end
	endtask

	// Sends R addr and collects the high then the low reply byte.
	task automatic fetch_word(input string name, input dbg_pkg::addr_t a,
		output dbg_pkg::data_t d);
		logic [7:0] hi;
		logic [7:0] lo;
		send_byte(dbg_pkg::op_read);
		send_byte(a);
		receive_byte(name, hi);
		receive_byte(name, lo);
		d = {hi, lo};
	endtask

	// One tck period; tdo is taken before the rising edge.
	task automatic tck_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(negedge clk);
		tdo_v = tdo;
		@(posedge clk);
		tms <= tms_v;
		tdi <= tdi_v;
		repeat (2) @(posedge clk);
		tck <= 1'b1;
		repeat (4) @(posedge clk);
		tck <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic tap_reset();
		logic unused_bit;
		repeat (5) tck_step(1'b1, 1'b0, unused_bit);
		tck_step(1'b0, 1'b0, unused_bit);
	endtask

	// Idle to idle through capture, 25 shifts and update.
	task automatic scan_dr(input logic [24:0] din, output logic [24:0] dout);
		logic bit_out;
		tck_step(1'b1, 1'b0, bit_out);
		tck_step(1'b0, 1'b0, bit_out);
		tck_step(1'b0, 1'b0, bit_out);
		for (int i = 0; i < 25; i++) begin
			tck_step(i == 24, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_step(1'b1, 1'b0, bit_out);
		tck_step(1'b0, 1'b0, bit_out);
	endtask

	// Command scan, then one read scan whose capture holds the result.
	task automatic debug_access(input string name, input logic wr,
		input dbg_pkg::addr_t a, input dbg_pkg::data_t d, output dbg_pkg::data_t rd);
		logic [24:0] rsp;
		scan_dr({wr, a, d}, rsp);
		scan_dr({1'b0, a, 16'h0000}, rsp);
		if (rsp[24] !== 1'b0) begin
			errors++;
			$display("%s: JTAG response still busy at the next capture", name);
		end
		check({name, "_pad"}, 16'd0, {8'd0, rsp[23:16]});
		rd = rsp[15:0];
	endtask

	task automatic load_cases();
		int fd;
		int n;
		string tok;
		string line;
		string port;
		string op;
		string dstr;
		string estr;
		dbg_pkg::addr_t a;
		fd = $fopen("test/board_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open test/board_cases.txt");
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					n = $fgets(line, fd);
				end else begin
					n = $fscanf(fd, "%s %s %h %s %s", port, op, a, dstr, estr);
					if (n != 5) begin
						errors++;
						$display("Case %s is malformed", tok);
					end else begin
						names.push_back(tok);
						ports.push_back(port);
						ops.push_back(op);
						addrs.push_back(a);
						datas.push_back(dstr);
						expects.push_back(estr);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic led_hold_test();
		repeat (3) begin
			@(posedge clk);
			tck <= 1'b1;
			repeat (4) @(posedge clk);
			tck <= 1'b0;
			repeat (3) @(posedge clk);
		end
		@(negedge clk);
		check("led_on", 16'd0, {15'd0, led});
		// Still lit near the end of the hold.
		repeat (`DBG_LED_HOLD - 8) @(negedge clk);
		check("led_hold", 16'd0, {15'd0, led});
		repeat (16) @(negedge clk);
		check("led_off", 16'd1, {15'd0, led});
	endtask

	// Port both puts UART on addr and JTAG on addr+1 with inverted data.
	task automatic run_case(input int k);
		dbg_pkg::data_t d;
		dbg_pkg::data_t exp;
		dbg_pkg::data_t got;
		dbg_pkg::data_t got_j;
		logic wr;
		int n;
		wr = ops[k] == "wr";
		d = '0;
		got = '0;
		got_j = '0;
		if (wr && datas[k] == "*")
			d = 16'($random(seed));
		else if (wr)
			n = $sscanf(datas[k], "%h", d);
		if (ports[k] == "uart") begin
			if (wr)
				bridge_write(names[k], addrs[k], d);
			else
				fetch_word(names[k], addrs[k], got);
		end else if (ports[k] == "jtag") begin
			debug_access(names[k], wr, addrs[k], d, got);
		end else begin
			fork
				begin
					// Lands the UART command near the JTAG update.
					repeat (160) @(posedge clk);
					if (wr)
						bridge_write(names[k], addrs[k], d);
					else
						fetch_word(names[k], addrs[k], got);
				end
				debug_access(names[k], wr, addrs[k] + 8'd1, ~d, got_j);
			join
		end
		if (wr) begin
			model[addrs[k]] = d;
			if (ports[k] == "both")
				model[addrs[k] + 8'd1] = ~d;
		end else begin
			if (expects[k] == "m")
				exp = model[addrs[k]];
			else
				n = $sscanf(expects[k], "%h", exp);
			check(names[k], exp, got);
			if (ports[k] == "both")
				check({names[k], "_jtag"}, model[addrs[k] + 8'd1], got_j);
		end
	endtask

	initial begin
		clk = 1'b0;
		button = 1'b1;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		uart_rx = 1'b1;
		seed = 74;
		errors = 0;
		checks = 0;
		cycles = 0;
		limit = 0;
		running = 1'b0;
		load_cases();
		// One extra slot covers reset and the LED test.
		limit = (names.size() + 1) * 2000;
		repeat (10) @(posedge clk);
		button <= 1'b0;
		repeat (2 * `DBG_RESET_STRETCH) @(posedge clk);
		running = 1'b1;
		@(negedge clk);
		check("reset_tx", 16'd1, {15'd0, uart_tx});
		check("reset_led", 16'd1, {15'd0, led});
		check("reset_tdo", 16'd0, {15'd0, tdo});
		led_hold_test();
		tap_reset();
		for (int k = 0; k < names.size(); k++)
			run_case(k);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== verilog/activity_led.sv ====
// LED output is active low.
`include "dbg_config.svh"

module activity_led (
	input  logic clk,
	input  logic reset,
	input  logic tck,
	output logic led
);

	localparam int hold_w = $clog2(`DBG_LED_HOLD + 1);

	logic [2:0] tck_sync;
	logic tck_edge;
	logic [hold_w-1:0] hold_count;

	// Either edge of the sampled tck.
	assign tck_edge = tck_sync[2] ^ tck_sync[1];

	always_ff @(posedge clk) begin
		tck_sync <= {tck_sync[1:0], tck};
	end

	always_ff @(posedge clk) begin
		if (reset)
			hold_count <= '0;
		else if (tck_edge)
			hold_count <= hold_w'(`DBG_LED_HOLD);
		else if (hold_count != '0)
			hold_count <= hold_count - 1'b1;
	end

	// Lit while the hold runs.
	assign led = hold_count == '0;

endmodule

// ==== verilog/bus_arbiter.sv ====
// m0 is the JTAG master, m1 the UART master.
// Grant is locked from the address handshake to the response handshake.
module bus_arbiter (
	input  logic           clk,
	input  logic           reset,
	input  logic           m0_awvalid,
	output logic           m0_awready,
	input  dbg_pkg::addr_t m0_awaddr,
	input  logic           m0_wvalid,
	output logic           m0_wready,
	input  dbg_pkg::data_t m0_wdata,
	output logic           m0_bvalid,
	input  logic           m0_bready,
	input  logic           m0_arvalid,
	output logic           m0_arready,
	input  dbg_pkg::addr_t m0_araddr,
	output logic           m0_rvalid,
	input  logic           m0_rready,
	output dbg_pkg::data_t m0_rdata,
	input  logic           m1_awvalid,
	output logic           m1_awready,
	input  dbg_pkg::addr_t m1_awaddr,
	input  logic           m1_wvalid,
	output logic           m1_wready,
	input  dbg_pkg::data_t m1_wdata,
	output logic           m1_bvalid,
	input  logic           m1_bready,
	input  logic           m1_arvalid,
	output logic           m1_arready,
	input  dbg_pkg::addr_t m1_araddr,
	output logic           m1_rvalid,
	input  logic           m1_rready,
	output dbg_pkg::data_t m1_rdata,
	output logic           s_awvalid,
	input  logic           s_awready,
	output dbg_pkg::addr_t s_awaddr,
	output logic           s_wvalid,
	input  logic           s_wready,
	output dbg_pkg::data_t s_wdata,
	input  logic           s_bvalid,
	output logic           s_bready,
	output logic           s_arvalid,
	input  logic           s_arready,
	output dbg_pkg::addr_t s_araddr,
	input  logic           s_rvalid,
	output logic           s_rready,
	input  dbg_pkg::data_t s_rdata
);

	logic req0;
	logic req1;
	logic pick;
	logic sel;
	logic locked;
	logic grant_sel;
	logic last;

	assign req0 = m0_awvalid || m0_arvalid;
	assign req1 = m1_awvalid || m1_arvalid;

	// Alternate on contention, else take whoever asks.
	assign pick = (req0 && req1) ? !last : req1;
	assign sel = locked ? grant_sel : pick;

	always_ff @(posedge clk) begin
		if (reset) begin
			locked <= 1'b0;
			grant_sel <= 1'b0;
			last <= 1'b1;
		end else if (!locked) begin
			if ((s_awvalid && s_awready) || (s_arvalid && s_arready)) begin
				locked <= 1'b1;
				grant_sel <= pick;
			end
		end else if ((s_bvalid && s_bready) || (s_rvalid && s_rready)) begin
			// Released; a new pick is seen next cycle.
			locked <= 1'b0;
			last <= grant_sel;
		end
	end

	// Request channels to the slave.
	assign s_awvalid = sel ? m1_awvalid : m0_awvalid;
	assign s_awaddr = sel ? m1_awaddr : m0_awaddr;
	assign s_wvalid = sel ? m1_wvalid : m0_wvalid;
	assign s_wdata = sel ? m1_wdata : m0_wdata;
	assign s_arvalid = sel ? m1_arvalid : m0_arvalid;
	assign s_araddr = sel ? m1_araddr : m0_araddr;
	assign s_bready = locked && (grant_sel ? m1_bready : m0_bready);
	assign s_rready = locked && (grant_sel ? m1_rready : m0_rready);

	// Readies back to the selected master.
	assign m0_awready = !sel && s_awready;
	assign m0_wready = !sel && s_wready;
	assign m0_arready = !sel && s_arready;
	assign m1_awready = sel && s_awready;
	assign m1_wready = sel && s_wready;
	assign m1_arready = sel && s_arready;

	// Responses only to the locked owner.
	assign m0_bvalid = locked && !grant_sel && s_bvalid;
	assign m0_rvalid = locked && !grant_sel && s_rvalid;
	assign m1_bvalid = locked && grant_sel && s_bvalid;
	assign m1_rvalid = locked && grant_sel && s_rvalid;
	assign m0_rdata = s_rdata;
	assign m1_rdata = s_rdata;

	a_resp_granted: assert property (@(posedge clk) disable iff (reset)
		(s_bvalid || s_rvalid) |-> locked);

endmodule

// ==== verilog/bus_ram.sv ====
// Single-beat slave; writes win over reads offered in the same cycle.
// Memory contents are undefined until written.
module bus_ram (
	input  logic           clk,
	input  logic           reset,
	input  logic           awvalid,
	output logic           awready,
	input  dbg_pkg::addr_t awaddr,
	input  logic           wvalid,
	output logic           wready,
	input  dbg_pkg::data_t wdata,
	output logic           bvalid,
	input  logic           bready,
	input  logic           arvalid,
	output logic           arready,
	input  dbg_pkg::addr_t araddr,
	output logic           rvalid,
	input  logic           rready,
	output dbg_pkg::data_t rdata
);

	import dbg_pkg::*;

	data_t mem [256];
	logic idle;

	// One response outstanding at a time.
	assign idle = !bvalid && !rvalid;
	assign awready = idle && awvalid && wvalid;
	assign wready = awready;
	assign arready = idle && arvalid && !(awvalid && wvalid);

	always_ff @(posedge clk) begin
		if (awready)
			mem[awaddr] <= wdata;
		if (arready)
			rdata <= mem[araddr];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (awready)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (arready)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

endmodule

// ==== verilog/dbg_config.svh ====
// Timing constants in system clock cycles.
// The UART bit period is set for simulation and must be raised for real baud rates.
`ifndef DBG_CONFIG_SVH
`define DBG_CONFIG_SVH

// Clocks per UART bit.
`define DBG_CLKS_PER_BIT 4

// Cycles reset stays high after its cause ends.
`define DBG_RESET_STRETCH 16

// Cycles the LED stays lit after a tck edge.
`define DBG_LED_HOLD 64

`endif

// ==== verilog/dbg_pkg.sv ====
// Shared bus widths, UART opcodes and the JTAG access register layout.
// The memory is fixed at 256 words of 16 bits.
package dbg_pkg;

	typedef logic [7:0]  addr_t;
	typedef logic [15:0] data_t;

	// UART command opcodes, ASCII W and R.
	typedef enum logic [7:0] {
		op_write = 8'h57,
		op_read  = 8'h52
	} uart_op_t;

	// Access register, one 25-bit shift word read two ways.
	typedef union packed {
		struct packed {
			logic  write;
			addr_t addr;
			data_t wdata;
		} cmd;
		struct packed {
			logic       busy;
			logic [7:0] zero;
			data_t      rdata;
		} rsp;
	} dr_word_t;

endpackage

// ==== verilog/fpga_board_top.sv ====
// Single clock domain; tck is oversampled by clk_osc.
// LED is active low; mirror pins copy the raw JTAG lines.
module fpga_board_top (
	input  logic clk_osc,
	input  logic button,
	input  logic tck,
	input  logic tms,
	input  logic tdi,
	output logic tdo,
	output logic led,
	output logic mirror_tck,
	output logic mirror_tms,
	output logic mirror_tdi,
	output logic mirror_tdo,
	input  logic uart_rx,
	output logic uart_tx
);

	import dbg_pkg::*;

	logic reset;
	logic [7:0] rx_byte;
	logic rx_valid;
	logic [7:0] tx_byte;
	logic tx_start;
	logic tx_busy;

	// JTAG master.
	logic m0_awvalid, m0_awready, m0_wvalid, m0_wready, m0_bvalid, m0_bready;
	logic m0_arvalid, m0_arready, m0_rvalid, m0_rready;
	addr_t m0_awaddr, m0_araddr;
	data_t m0_wdata, m0_rdata;
	// UART master.
	logic m1_awvalid, m1_awready, m1_wvalid, m1_wready, m1_bvalid, m1_bready;
	logic m1_arvalid, m1_arready, m1_rvalid, m1_rready;
	addr_t m1_awaddr, m1_araddr;
	data_t m1_wdata, m1_rdata;
	// Memory side.
	logic s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
	logic s_arvalid, s_arready, s_rvalid, s_rready;
	addr_t s_awaddr, s_araddr;
	data_t s_wdata, s_rdata;

	assign mirror_tck = tck;
	assign mirror_tms = tms;
	assign mirror_tdi = tdi;
	assign mirror_tdo = tdo;

	fpga_reset fpga_reset_inst (
		.clk    (clk_osc),
		.button (button),
		.reset  (reset)
	);

	activity_led activity_led_inst (
		.clk   (clk_osc),
		.reset (reset),
		.tck   (tck),
		.led   (led)
	);

	uart_serial uart_serial_inst (
		.clk      (clk_osc),
		.reset    (reset),
		.rx       (uart_rx),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.tx_busy  (tx_busy),
		.tx       (uart_tx)
	);

	uart_bridge uart_bridge_inst (
		.clk      (clk_osc),
		.reset    (reset),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.tx_busy  (tx_busy),
		.awvalid  (m1_awvalid),
		.awready  (m1_awready),
		.awaddr   (m1_awaddr),
		.wvalid   (m1_wvalid),
		.wready   (m1_wready),
		.wdata    (m1_wdata),
		.bvalid   (m1_bvalid),
		.bready   (m1_bready),
		.arvalid  (m1_arvalid),
		.arready  (m1_arready),
		.araddr   (m1_araddr),
		.rvalid   (m1_rvalid),
		.rready   (m1_rready),
		.rdata    (m1_rdata)
	);

	jtag_dtm jtag_dtm_inst (
		.clk     (clk_osc),
		.reset   (reset),
		.tck     (tck),
		.tms     (tms),
		.tdi     (tdi),
		.tdo     (tdo),
		.awvalid (m0_awvalid),
		.awready (m0_awready),
		.awaddr  (m0_awaddr),
		.wvalid  (m0_wvalid),
		.wready  (m0_wready),
		.wdata   (m0_wdata),
		.bvalid  (m0_bvalid),
		.bready  (m0_bready),
		.arvalid (m0_arvalid),
		.arready (m0_arready),
		.araddr  (m0_araddr),
		.rvalid  (m0_rvalid),
		.rready  (m0_rready),
		.rdata   (m0_rdata)
	);

	bus_arbiter bus_arbiter_inst (
		.clk (clk_osc),
		.reset (reset),
		.m0_awvalid (m0_awvalid), .m0_awready (m0_awready), .m0_awaddr (m0_awaddr),
		.m0_wvalid  (m0_wvalid),  .m0_wready  (m0_wready),  .m0_wdata  (m0_wdata),
		.m0_bvalid  (m0_bvalid),  .m0_bready  (m0_bready),
		.m0_arvalid (m0_arvalid), .m0_arready (m0_arready), .m0_araddr (m0_araddr),
		.m0_rvalid  (m0_rvalid),  .m0_rready  (m0_rready),  .m0_rdata  (m0_rdata),
		.m1_awvalid (m1_awvalid), .m1_awready (m1_awready), .m1_awaddr (m1_awaddr),
		.m1_wvalid  (m1_wvalid),  .m1_wready  (m1_wready),  .m1_wdata  (m1_wdata),
		.m1_bvalid  (m1_bvalid),  .m1_bready  (m1_bready),
		.m1_arvalid (m1_arvalid), .m1_arready (m1_arready), .m1_araddr (m1_araddr),
		.m1_rvalid  (m1_rvalid),  .m1_rready  (m1_rready),  .m1_rdata  (m1_rdata),
		.s_awvalid  (s_awvalid),  .s_awready  (s_awready),  .s_awaddr  (s_awaddr),
		.s_wvalid   (s_wvalid),   .s_wready   (s_wready),   .s_wdata   (s_wdata),
		.s_bvalid   (s_bvalid),   .s_bready   (s_bready),
		.s_arvalid  (s_arvalid),  .s_arready  (s_arready),  .s_araddr  (s_araddr),
		.s_rvalid   (s_rvalid),   .s_rready   (s_rready),   .s_rdata   (s_rdata)
	);

	bus_ram bus_ram_inst (
		.clk     (clk_osc),
		.reset   (reset),
		.awvalid (s_awvalid),
		.awready (s_awready),
		.awaddr  (s_awaddr),
		.wvalid  (s_wvalid),
		.wready  (s_wready),
		.wdata   (s_wdata),
		.bvalid  (s_bvalid),
		.bready  (s_bready),
		.arvalid (s_arvalid),
		.arready (s_arready),
		.araddr  (s_araddr),
		.rvalid  (s_rvalid),
		.rready  (s_rready),
		.rdata   (s_rdata)
	);

endmodule

// ==== verilog/fpga_reset.sv ====
// Power-on relies on the FPGA loading the initial counter value.
// The button is asynchronous and is synchronized here.
`include "dbg_config.svh"

module fpga_reset (
	input  logic clk,
	input  logic button,
	output logic reset
);

	localparam int stretch_w = $clog2(`DBG_RESET_STRETCH + 1);

	// Counts up once after configuration.
	logic [3:0] por_count = '0;
	logic por_active;
	logic [1:0] button_sync;
	logic [stretch_w-1:0] stretch_count;

	assign por_active = por_count != 4'hf;

	always_ff @(posedge clk) begin
		if (por_active)
			por_count <= por_count + 4'd1;
		button_sync <= {button_sync[0], button};
	end

	// Reloaded while any cause is present.
	always_ff @(posedge clk) begin
		if (por_active || button_sync[1])
			stretch_count <= stretch_w'(`DBG_RESET_STRETCH);
		else if (stretch_count != '0)
			stretch_count <= stretch_count - 1'b1;
	end

	assign reset = por_active || button_sync[1] || (stretch_count != '0);

endmodule

// ==== verilog/jtag_dtm.sv ====
// tck is sampled as data and must be well below a quarter of clk.
// IR value 1 selects the access register; no IDCODE or BYPASS.
module jtag_dtm (
	input  logic           clk,
	input  logic           reset,
	input  logic           tck,
	input  logic           tms,
	input  logic           tdi,
	output logic           tdo,
	output logic           awvalid,
	input  logic           awready,
	output dbg_pkg::addr_t awaddr,
	output logic           wvalid,
	input  logic           wready,
	output dbg_pkg::data_t wdata,
	input  logic           bvalid,
	output logic           bready,
	output logic           arvalid,
	input  logic           arready,
	output dbg_pkg::addr_t araddr,
	input  logic           rvalid,
	output logic           rready,
	input  dbg_pkg::data_t rdata
);

	import dbg_pkg::*;

	// Standard TAP encoding.
	localparam logic [3:0] st_reset     = 4'hf;
	localparam logic [3:0] st_idle      = 4'hc;
	localparam logic [3:0] st_sel_dr    = 4'h7;
	localparam logic [3:0] st_cap_dr    = 4'h6;
	localparam logic [3:0] st_shift_dr  = 4'h2;
	localparam logic [3:0] st_exit1_dr  = 4'h1;
	localparam logic [3:0] st_pause_dr  = 4'h3;
	localparam logic [3:0] st_exit2_dr  = 4'h0;
	localparam logic [3:0] st_upd_dr    = 4'h5;
	localparam logic [3:0] st_sel_ir    = 4'h4;
	localparam logic [3:0] st_cap_ir    = 4'he;
	localparam logic [3:0] st_shift_ir  = 4'ha;
	localparam logic [3:0] st_exit1_ir  = 4'h9;
	localparam logic [3:0] st_pause_ir  = 4'hb;
	localparam logic [3:0] st_exit2_ir  = 4'h8;
	localparam logic [3:0] st_upd_ir    = 4'hd;

	logic [2:0] tck_sync;
	logic [1:0] tms_sync;
	logic [1:0] tdi_sync;
	logic tck_rise;
	logic tck_fall;
	logic [3:0] state;
	logic [3:0] next_state;
	logic ir;
	logic ir_shift;
	dr_word_t dr;
	logic busy;
	data_t rdata_q;
	addr_t addr_q;
	data_t wdata_q;

	always_ff @(posedge clk) begin
		tck_sync <= {tck_sync[1:0], tck};
		tms_sync <= {tms_sync[0], tms};
		tdi_sync <= {tdi_sync[0], tdi};
	end

	assign tck_rise = tck_sync[1] && !tck_sync[2];
	assign tck_fall = !tck_sync[1] && tck_sync[2];

	always_comb begin
		case (state)
			st_reset:    next_state = tms_sync[1] ? st_reset : st_idle;
			st_idle:     next_state = tms_sync[1] ? st_sel_dr : st_idle;
			st_sel_dr:   next_state = tms_sync[1] ? st_sel_ir : st_cap_dr;
			st_cap_dr:   next_state = tms_sync[1] ? st_exit1_dr : st_shift_dr;
			st_shift_dr: next_state = tms_sync[1] ? st_exit1_dr : st_shift_dr;
			st_exit1_dr: next_state = tms_sync[1] ? st_upd_dr : st_pause_dr;
			st_pause_dr: next_state = tms_sync[1] ? st_exit2_dr : st_pause_dr;
			st_exit2_dr: next_state = tms_sync[1] ? st_upd_dr : st_shift_dr;
			st_upd_dr:   next_state = tms_sync[1] ? st_sel_dr : st_idle;
			st_sel_ir:   next_state = tms_sync[1] ? st_reset : st_cap_ir;
			st_cap_ir:   next_state = tms_sync[1] ? st_exit1_ir : st_shift_ir;
			st_shift_ir: next_state = tms_sync[1] ? st_exit1_ir : st_shift_ir;
			st_exit1_ir: next_state = tms_sync[1] ? st_upd_ir : st_pause_ir;
			st_pause_ir: next_state = tms_sync[1] ? st_exit2_ir : st_pause_ir;
			st_exit2_ir: next_state = tms_sync[1] ? st_upd_ir : st_shift_ir;
			default:     next_state = tms_sync[1] ? st_sel_dr : st_idle;
		endcase
	end

	// TAP steps, IR, and the tdo launch on the falling edge.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_reset;
			ir <= 1'b1;
			tdo <= 1'b0;
		end else begin
			if (tck_rise) begin
				state <= next_state;
				if (state == st_reset)
					ir <= 1'b1;
				if (state == st_upd_ir)
					ir <= ir_shift;
			end
			if (tck_fall) begin
				if (state == st_shift_dr && ir)
					tdo <= dr[0];
				else if (state == st_shift_ir)
					tdo <= ir_shift;
				else
					tdo <= 1'b0;
			end
		end
	end

	// Shift registers carry no reset.
	always_ff @(posedge clk) begin
		if (tck_rise) begin
			if (state == st_cap_ir)
				ir_shift <= 1'b1;
			else if (state == st_shift_ir)
				ir_shift <= tdi_sync[1];
			if (ir && state == st_cap_dr) begin
				dr.rsp.busy <= busy;
				dr.rsp.zero <= '0;
				dr.rsp.rdata <= rdata_q;
			end else if (ir && state == st_shift_dr) begin
				dr <= {tdi_sync[1], dr[24:1]};
			end
		end
	end

	// Bus side, one transaction per update.
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			if (tck_rise && ir && state == st_upd_dr && !busy) begin
				busy <= 1'b1;
				addr_q <= dr.cmd.addr;
				wdata_q <= dr.cmd.wdata;
				awvalid <= dr.cmd.write;
				wvalid <= dr.cmd.write;
				arvalid <= !dr.cmd.write;
			end
			if (awready)
				awvalid <= 1'b0;
			if (wready)
				wvalid <= 1'b0;
			if (arready)
				arvalid <= 1'b0;
			if (bvalid && bready)
				busy <= 1'b0;
			if (rvalid && rready) begin
				rdata_q <= rdata;
				busy <= 1'b0;
			end
		end
	end

	assign awaddr = addr_q;
	assign araddr = addr_q;
	assign wdata = wdata_q;
	assign bready = busy;
	assign rready = busy;

	a_one_request: assert property (@(posedge clk) disable iff (reset)
		!(arvalid && awvalid));

endmodule

// ==== verilog/uart_bridge.sv ====
// Commands are W addr hi lo and R addr; a read replies hi then lo.
// Bytes that arrive while a command is in flight are lost.
module uart_bridge (
	input  logic           clk,
	input  logic           reset,
	input  logic [7:0]     rx_byte,
	input  logic           rx_valid,
	output logic [7:0]     tx_byte,
	output logic           tx_start,
	input  logic           tx_busy,
	output logic           awvalid,
	input  logic           awready,
	output dbg_pkg::addr_t awaddr,
	output logic           wvalid,
	input  logic           wready,
	output dbg_pkg::data_t wdata,
	input  logic           bvalid,
	output logic           bready,
	output logic           arvalid,
	input  logic           arready,
	output dbg_pkg::addr_t araddr,
	input  logic           rvalid,
	output logic           rready,
	input  dbg_pkg::data_t rdata
);

	import dbg_pkg::*;

	localparam logic [3:0] s_op   = 4'd0;
	localparam logic [3:0] s_addr = 4'd1;
	localparam logic [3:0] s_dhi  = 4'd2;
	localparam logic [3:0] s_dlo  = 4'd3;
	localparam logic [3:0] s_wr   = 4'd4;
	localparam logic [3:0] s_rd   = 4'd5;
	localparam logic [3:0] s_txh  = 4'd6;
	localparam logic [3:0] s_txl  = 4'd7;
	localparam logic [3:0] s_txw  = 4'd8;

	logic [3:0] state;
	logic is_write;
	addr_t addr_q;
	data_t data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_op;
			is_write <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			case (state)
				s_op: if (rx_valid) begin
					// Unknown opcodes are dropped.
					is_write <= rx_byte == op_write;
					if (rx_byte == op_write || rx_byte == op_read)
						state <= s_addr;
				end
				s_addr: if (rx_valid) begin
					addr_q <= rx_byte;
					arvalid <= !is_write;
					state <= is_write ? s_dhi : s_rd;
				end
				s_dhi: if (rx_valid) begin
					data_q[15:8] <= rx_byte;
					state <= s_dlo;
				end
				s_dlo: if (rx_valid) begin
					data_q[7:0] <= rx_byte;
					awvalid <= 1'b1;
					wvalid <= 1'b1;
					state <= s_wr;
				end
				s_wr: begin
					if (awready)
						awvalid <= 1'b0;
					if (wready)
						wvalid <= 1'b0;
					if (bvalid)
						state <= s_op;
				end
				s_rd: begin
					if (arready)
						arvalid <= 1'b0;
					if (rvalid) begin
						data_q <= rdata;
						state <= s_txh;
					end
				end
				s_txh: if (!tx_busy)
					state <= s_txl;
				s_txl: if (!tx_busy)
					state <= s_txw;
				// Wait out the low byte's stop bit.
				default: if (!tx_busy)
					state <= s_op;
			endcase
		end
	end

	assign awaddr = addr_q;
	assign araddr = addr_q;
	assign wdata = data_q;
	assign bready = state == s_wr;
	assign rready = state == s_rd;

	// Handshake with the serial block within one cycle.
	assign tx_start = (state == s_txh || state == s_txl) && !tx_busy;
	assign tx_byte = (state == s_txh) ? data_q[15:8] : data_q[7:0];

	a_aw_held: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid);

endmodule

// ==== verilog/uart_serial.sv ====
// 8N1 only, no parity, no flow control.
// A byte with a bad stop bit is dropped without notice.
`include "dbg_config.svh"

module uart_serial (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_valid,
	input  logic [7:0] tx_byte,
	input  logic       tx_start,
	output logic       tx_busy,
	output logic       tx
);

	localparam int cnt_w = $clog2(`DBG_CLKS_PER_BIT + 1);
	localparam logic [cnt_w-1:0] bit_end = cnt_w'(`DBG_CLKS_PER_BIT - 1);
	localparam logic [cnt_w-1:0] bit_mid = cnt_w'(`DBG_CLKS_PER_BIT / 2 - 1);

	localparam logic [1:0] rx_idle  = 2'd0;
	localparam logic [1:0] rx_start = 2'd1;
	localparam logic [1:0] rx_data  = 2'd2;
	localparam logic [1:0] rx_stop  = 2'd3;

	logic [1:0] rx_sync;
	logic [1:0] rx_state;
	logic [cnt_w-1:0] rx_count;
	logic [2:0] rx_bit;
	logic [7:0] rx_shift;

	logic [cnt_w-1:0] tx_count;
	logic [3:0] tx_bit;
	logic [9:0] tx_frame;

	always_ff @(posedge clk) begin
		rx_sync <= {rx_sync[0], rx};
	end

	// Receiver, sampling at bit centres.
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_state <= rx_idle;
			rx_count <= '0;
			rx_bit <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			rx_count <= rx_count + 1'b1;
			case (rx_state)
				rx_idle: begin
					rx_count <= '0;
					if (!rx_sync[1])
						rx_state <= rx_start;
				end
				rx_start: if (rx_count == bit_mid) begin
					// Glitch check at start centre.
					rx_count <= '0;
					rx_bit <= '0;
					rx_state <= rx_sync[1] ? rx_idle : rx_data;
				end
				rx_data: if (rx_count == bit_end) begin
					rx_count <= '0;
					rx_bit <= rx_bit + 3'd1;
					if (rx_bit == 3'd7)
						rx_state <= rx_stop;
				end
				default: if (rx_count == bit_end) begin
					rx_valid <= rx_sync[1];
					rx_state <= rx_idle;
				end
			endcase
		end
	end

	// LSB first.
	always_ff @(posedge clk) begin
		if (rx_state == rx_data && rx_count == bit_end)
			rx_shift <= {rx_sync[1], rx_shift[7:1]};
	end

	assign rx_byte = rx_shift;

	// Transmitter, frame shifts out LSB first.
	always_ff @(posedge clk) begin
		if (reset) begin
			tx_busy <= 1'b0;
			tx_count <= '0;
			tx_bit <= '0;
			tx_frame <= '1;
		end else if (tx_start && !tx_busy) begin
			tx_busy <= 1'b1;
			tx_count <= '0;
			tx_bit <= '0;
			tx_frame <= {1'b1, tx_byte, 1'b0};
		end else if (tx_busy) begin
			tx_count <= tx_count + 1'b1;
			if (tx_count == bit_end) begin
				tx_count <= '0;
				tx_bit <= tx_bit + 4'd1;
				tx_frame <= {1'b1, tx_frame[9:1]};
				// Done after the stop bit.
				if (tx_bit == 4'd9)
					tx_busy <= 1'b0;
			end
		end
	end

	assign tx = tx_frame[0];

	a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
		!(tx_start && tx_busy));

endmodule
